//--- tb.f
+incdir+.
corePkg.sv
managementPort.sv
instructionFetch.sv
fetchQueue.sv
executeUnit.sv
registerFile.sv
integerCore.sv
integerCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f tb.f --top-module integerCoreTb
output=$(./obj_dir/VintegerCoreTb)
echo "$output"

if echo "$output" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1

//--- integerCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module integerCoreTb import corePkg::*; ();

	localparam int clockPeriod = 20;
	localparam int seed = 83;
	localparam int totalInstructions = 24 + 24 + 12;
	localparam int maxShiftCost = 34;
	localparam int watchdogTime = totalInstructions * maxShiftCost * clockPeriod + 40000;
	localparam logic [15:0] pcAddress = `MGMT_PC_OFFSET;
	localparam logic [15:0] clearErrorAddress = `MGMT_CLEAR_ERROR_OFFSET;
	localparam logic [15:0] registerBase = {`MGMT_REGION_REGISTERS, 14'h0};

	logic clk;
	logic rst;
	logic [`XLEN-1:0] instrAddress;
	logic instrEnable;
	logic [`XLEN-1:0] instrData;
	logic instrBusy;
	mgmtRequest_t mgmt;
	logic run;
	logic [`XLEN-1:0] mgmtReadData;
	logic idle;
	logic error;

	logic [`XLEN-1:0] progMem [64];
	logic [`XLEN-1:0] modelRegs [`REG_COUNT];
	logic [`XLEN-1:0] programBase;
	logic [`XLEN-1:0] endAddress;
	logic [31:0] progState;
	logic [31:0] busyState;
	logic busyRandom;
	int busyLevel;
	int errorCount;
	int checkCount;

	integerCore integerCore_inst (
		.clk(clk),
		.rst(rst),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.instrData(instrData),
		.instrBusy(instrBusy),
		.mgmt(mgmt),
		.run(run),
		.mgmtReadData(mgmtReadData),
		.idle(idle),
		.error(error));

	initial begin
		clk = 1'b0;
		forever #(clockPeriod / 2) clk = ~clk;
	end

	// Instruction memory, parks fetch at the end address by holding busy
	always_comb begin
		if (instrAddress >= programBase && instrAddress < endAddress) begin
			instrData = progMem[6'((instrAddress - programBase) >> 2)];
		end else begin
			instrData = ~instrAddress;
		end
		instrBusy = (instrAddress == endAddress) || busyRandom;
	end

	always @(posedge clk) begin
		busyState = xorshift(busyState);
		busyRandom <= busyState[1:0] < busyLevel;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] randomInstruction(input logic [31:0] r,
			input logic shiftHeavy);
		logic [3:0] kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		kind = r[3:0];
		rd = r[8:4];
		rs1 = r[13:9];
		rs2 = r[18:14];
		// Lean on shifts to fill the queue
		if (shiftHeavy && r[19]) begin
			kind = 4'd5 + 4'(r[1:0] % 3);
		end
		case (kind)
			4'd0: randomInstruction = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			4'd1: randomInstruction = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			4'd2: randomInstruction = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			4'd3: randomInstruction = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			4'd4: randomInstruction = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			4'd5: randomInstruction = {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
			4'd6: randomInstruction = {7'b0000000, rs2, rs1, 3'b101, rd, 7'b0110011};
			4'd7: randomInstruction = {7'b0100000, rs2, rs1, 3'b101, rd, 7'b0110011};
			4'd9: randomInstruction = {r[31:20], rs1, 3'b100, rd, 7'b0010011};
			4'd10: randomInstruction = {r[31:20], rs1, 3'b110, rd, 7'b0010011};
			4'd11: randomInstruction = {r[31:20], rs1, 3'b111, rd, 7'b0010011};
			4'd12: randomInstruction = {r[31:12], rd, 7'b0110111};
			default: randomInstruction = {r[31:20], rs1, 3'b000, rd, 7'b0010011};
		endcase
	endfunction

	// RV32I semantics of the kept subset, anything else is illegal
	function automatic logic [31:0] referenceResult(input logic [31:0] instr,
			input logic [31:0] a, input logic [31:0] b, output logic legal);
		logic [31:0] imm;
		imm = {{20{instr[31]}}, instr[31:20]};
		legal = 1'b1;
		referenceResult = 32'h0;
		case (instr[6:0])
			7'b0110011: begin
				case ({instr[31:25], instr[14:12]})
					10'b0000000_000: referenceResult = a + b;
					10'b0100000_000: referenceResult = a - b;
					10'b0000000_100: referenceResult = a ^ b;
					10'b0000000_110: referenceResult = a | b;
					10'b0000000_111: referenceResult = a & b;
					10'b0000000_001: referenceResult = a << b[4:0];
					10'b0000000_101: referenceResult = a >> b[4:0];
					10'b0100000_101: referenceResult = $signed(a) >>> b[4:0];
					default: legal = 1'b0;
				endcase
			end
			7'b0010011: begin
				case (instr[14:12])
					3'b000: referenceResult = a + imm;
					3'b100: referenceResult = a ^ imm;
					3'b110: referenceResult = a | imm;
					3'b111: referenceResult = a & imm;
					default: legal = 1'b0;
				endcase
			end
			7'b0110111: referenceResult = {instr[31:12], 12'h0};
			default: legal = 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] maskBytes(input logic [31:0] value, input logic [3:0] select);
		for (int i = 0; i < 4; i++) begin
			if (!select[i]) begin
				value[i*8 +: 8] = 8'h00;
			end
		end
		return value;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string message);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s: got %h, expected %h", $time, message, actual,
				expected);
		end
	endtask

	task automatic writeManagement(input logic [15:0] address, input logic [31:0] data);
		@(posedge clk);
		mgmt <= '{writeEnable: 1'b1, byteSelect: 4'hf, address: address, writeData: data};
		@(posedge clk);
		mgmt <= '{writeEnable: 1'b0, byteSelect: 4'hf, address: address, writeData: 32'h0};
	endtask

	task automatic readManagement(input logic [15:0] address, input logic [3:0] select,
			output logic [31:0] data);
		@(posedge clk);
		mgmt <= '{writeEnable: 1'b0, byteSelect: select, address: address, writeData: 32'h0};
		@(negedge clk);
		data = mgmtReadData;
	endtask

	task automatic waitForParking(input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!(instrAddress == endAddress && instrBusy) && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= limit) begin
			errorCount++;
			$display("Fetch did not reach the end of the program within %0d cycles", limit);
		end
	endtask

	task automatic waitForIdle(input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!idle && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= limit) begin
			errorCount++;
			$display("Core did not go idle within %0d cycles after halt", limit);
		end
	endtask

	task automatic runProgram(input int length, input logic [31:0] base, input int busyChance,
			input logic shiftHeavy, input logic withIllegal);
		logic [31:0] value;
		logic [31:0] instr;
		logic [31:0] result;
		logic legal;
		logic expectError;
		int limit;
		// Preload, the write to x0 must not stick
		for (int i = 0; i < `REG_COUNT; i++) begin
			progState = xorshift(progState);
			value = shiftHeavy ? (progState | 32'h18) : progState;
			writeManagement(registerBase + 16'(i * 4), value);
			modelRegs[i] = (i == 0) ? 32'h0 : value;
		end
		programBase = base;
		endAddress = base + 32'(length * 4);
		expectError = 1'b0;
		for (int i = 0; i < length; i++) begin
			progState = xorshift(progState);
			instr = randomInstruction(progState, shiftHeavy);
			if (i % 8 == 3) begin
				instr[11:7] = 5'd0;
			end
			if (withIllegal) begin
				case (i)
					2: instr = 32'h0020_9093;
					6: instr = 32'h0000_0000;
					9: instr = 32'h0220_81b3;
					default: ;
				endcase
			end
			progMem[i] = instr;
			result = referenceResult(instr, modelRegs[instr[19:15]], modelRegs[instr[24:20]],
				legal);
			if (!legal) begin
				expectError = 1'b1;
			end else if (instr[11:7] != 5'd0) begin
				modelRegs[instr[11:7]] = result;
			end
		end
		writeManagement(pcAddress, base);
		readManagement(pcAddress, 4'hf, value);
		checkValue(value, base, "PC after set");
		busyLevel = busyChance;
		@(posedge clk);
		run <= 1'b1;
		limit = length * 40 + 100;
		waitForParking(limit);
		@(posedge clk);
		run <= 1'b0;
		waitForIdle(limit);
		busyLevel = 0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			readManagement(registerBase + 16'(i * 4), 4'hf, value);
			checkValue(value, modelRegs[i], $sformatf("x%0d after program at %h", i, base));
		end
		readManagement(pcAddress, 4'hf, value);
		checkValue(value, endAddress, "PC after halt");
		checkValue(error, expectError, "error flag after program");
	endtask

	initial begin
		logic [31:0] value;
		logic [15:0] unmapped [4];
		unmapped = '{16'h8000, 16'h0100, 16'h4080, 16'hc004};
		rst = 1'b1;
		run = 1'b0;
		mgmt = '0;
		busyRandom = 1'b0;
		busyLevel = 0;
		programBase = 32'h0;
		endAddress = 32'h0;
		progState = 32'(seed);
		busyState = xorshift(32'(seed));
		errorCount = 0;
		checkCount = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		checkValue(idle, 1'b1, "idle after reset");
		checkValue(error, 1'b0, "error after reset");
		checkValue(instrEnable, 1'b0, "instrEnable after reset");
		readManagement(pcAddress, 4'hf, value);
		checkValue(value, 32'h0, "PC after reset");

		runProgram(24, 32'h0000_0100, 1, 1'b0, 1'b0);
		// Long shifts with busy most of the time
		runProgram(24, 32'h0000_0400, 3, 1'b1, 1'b0);
		runProgram(12, 32'h0000_0800, 1, 1'b0, 1'b1);

		writeManagement(clearErrorAddress, 32'h0);
		@(negedge clk);
		checkValue(error, 1'b0, "error after clear");

		writeManagement(registerBase + 16'd20, 32'h1234_5678);
		for (int s = 0; s < 16; s++) begin
			readManagement(registerBase + 16'd20, 4'(s), value);
			checkValue(value, maskBytes(32'h1234_5678, 4'(s)), $sformatf("x5 select %b", 4'(s)));
		end
		readManagement(pcAddress, 4'b0110, value);
		checkValue(value, maskBytes(endAddress, 4'b0110), "PC with partial select");
		for (int i = 0; i < 4; i++) begin
			readManagement(unmapped[i], 4'hf, value);
			checkValue(value, 32'hffff_ffff, $sformatf("unmapped read at %h", unmapped[i]));
		end

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdogTime);
		$display("Watchdog expired after %0d ns before the tests finished", watchdogTime);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- integerCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module integerCore import corePkg::*; (
	input wire clk,
	input wire rst,
	output logic [`XLEN-1:0] instrAddress,
	output logic instrEnable,
	input wire [`XLEN-1:0] instrData,
	input wire instrBusy,
	input mgmtRequest_t mgmt,
	input wire run,
	output logic [`XLEN-1:0] mgmtReadData,
	output logic idle,
	output logic error
);

	logic running;
	pcWrite_t pcWrite;
	logic [`REG_INDEX_WIDTH-1:0] mgmtRegIndex;
	regWrite_t mgmtRegWrite;
	logic [`XLEN-1:0] mgmtRegData;
	logic [`XLEN-1:0] fetchPc;
	logic push;
	fetchEntry_t pushEntry;
	logic creditReturn;
	logic pop;
	logic headValid;
	fetchEntry_t headEntry;
	logic queueEmpty;
	logic [`REG_INDEX_WIDTH-1:0] rs1Index;
	logic [`REG_INDEX_WIDTH-1:0] rs2Index;
	logic [`XLEN-1:0] rs1Data;
	logic [`XLEN-1:0] rs2Data;
	regWrite_t execRegWrite;
	logic illegal;
	logic executeBusy;

	// Halted with nothing left in flight
	assign idle = !running && queueEmpty && !executeBusy;

	managementPort managementPort_inst (
		.clk(clk),
		.rst(rst),
		.run(run),
		.req(mgmt),
		.idle(idle),
		.pc(fetchPc),
		.regReadData(mgmtRegData),
		.illegal(illegal),
		.running(running),
		.pcWrite(pcWrite),
		.regIndex(mgmtRegIndex),
		.regWrite(mgmtRegWrite),
		.readData(mgmtReadData),
		.error(error));

	instructionFetch instructionFetch_inst (
		.clk(clk),
		.rst(rst),
		.running(running),
		.pcWrite(pcWrite),
		.instrAddress(instrAddress),
		.instrEnable(instrEnable),
		.instrData(instrData),
		.instrBusy(instrBusy),
		.creditReturn(creditReturn),
		.push(push),
		.pushEntry(pushEntry),
		.fetchPc(fetchPc));

	fetchQueue fetchQueue_inst (
		.clk(clk),
		.rst(rst),
		.push(push),
		.pushEntry(pushEntry),
		.pop(pop),
		.headValid(headValid),
		.headEntry(headEntry),
		.creditReturn(creditReturn),
		.empty(queueEmpty));

	executeUnit executeUnit_inst (
		.clk(clk),
		.rst(rst),
		.headValid(headValid),
		.headEntry(headEntry),
		.pop(pop),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.regWrite(execRegWrite),
		.illegal(illegal),
		.busy(executeBusy));

	registerFile registerFile_inst (
		.clk(clk),
		.rs1Index(rs1Index),
		.rs2Index(rs2Index),
		.mgmtIndex(mgmtRegIndex),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtData(mgmtRegData),
		.execWrite(execRegWrite),
		.mgmtWrite(mgmtRegWrite));

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module registerFile import corePkg::*; (
	input wire clk,
	input wire [`REG_INDEX_WIDTH-1:0] rs1Index,
	input wire [`REG_INDEX_WIDTH-1:0] rs2Index,
	input wire [`REG_INDEX_WIDTH-1:0] mgmtIndex,
	output logic [`XLEN-1:0] rs1Data,
	output logic [`XLEN-1:0] rs2Data,
	output logic [`XLEN-1:0] mgmtData,
	input regWrite_t execWrite,
	input regWrite_t mgmtWrite
);

	logic [`XLEN-1:0] registers [`REG_COUNT];

	// x0 is hardwired to zero
	assign rs1Data = (rs1Index == '0) ? '0 : registers[rs1Index];
	assign rs2Data = (rs2Index == '0) ? '0 : registers[rs2Index];
	assign mgmtData = (mgmtIndex == '0) ? '0 : registers[mgmtIndex];

	always_ff @(posedge clk) begin
		if (execWrite.enable && execWrite.index != '0) begin
			registers[execWrite.index] <= execWrite.data;
		end
		if (mgmtWrite.enable && mgmtWrite.index != '0) begin
			registers[mgmtWrite.index] <= mgmtWrite.data;
		end
	end

	singleWriter: assert property (@(posedge clk)
		!(execWrite.enable && mgmtWrite.enable));

endmodule

`default_nettype wire

//--- executeUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module executeUnit import corePkg::*; (
	input wire clk,
	input wire rst,
	input wire headValid,
	input fetchEntry_t headEntry,
	output logic pop,
	output logic [`REG_INDEX_WIDTH-1:0] rs1Index,
	output logic [`REG_INDEX_WIDTH-1:0] rs2Index,
	input wire [`XLEN-1:0] rs1Data,
	input wire [`XLEN-1:0] rs2Data,
	output regWrite_t regWrite,
	output logic illegal,
	output logic busy
);

	logic [`XLEN-1:0] instr;
	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	aluOp_t aluOp;
	logic legal;
	logic isShift;
	logic [`XLEN-1:0] operandA;
	logic [`XLEN-1:0] operandB;
	logic [`XLEN-1:0] aluResult;
	logic shifting;
	logic [`XLEN-1:0] shiftValue;
	logic [4:0] shiftCount;
	logic [`XLEN-1:0] nextShiftValue;
	logic shiftDone;

	assign instr = headEntry.instruction;
	assign opcode = opcode_t'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1Index = instr[19:15];
	assign rs2Index = instr[24:20];

	// funct3 matches the RV32I encoding for the kept operations
	always_comb begin
		aluOp = aluAdd;
		legal = 1'b0;
		case (opcode)
			opcodeOp: begin
				legal = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: aluOp = aluAdd;
					10'b0100000_000: aluOp = aluSub;
					10'b0000000_100: aluOp = aluXor;
					10'b0000000_110: aluOp = aluOr;
					10'b0000000_111: aluOp = aluAnd;
					10'b0000000_001: aluOp = aluSll;
					10'b0000000_101: aluOp = aluSrl;
					10'b0100000_101: aluOp = aluSra;
					default: legal = 1'b0;
				endcase
			end
			opcodeOpImm: begin
				legal = 1'b1;
				case (funct3)
					3'b000: aluOp = aluAdd;
					3'b100: aluOp = aluXor;
					3'b110: aluOp = aluOr;
					3'b111: aluOp = aluAnd;
					default: legal = 1'b0;
				endcase
			end
			opcodeLui: legal = 1'b1;
			default: legal = 1'b0;
		endcase
	end

	assign isShift = legal && (aluOp == aluSll || aluOp == aluSrl || aluOp == aluSra);

	// LUI is an add of the upper immediate to zero
	assign operandA = (opcode == opcodeLui) ? '0 : rs1Data;
	always_comb begin
		if (opcode == opcodeOp) begin
			operandB = rs2Data;
		end else if (opcode == opcodeLui) begin
			operandB = {instr[31:12], 12'b0};
		end else begin
			operandB = {{(`XLEN-12){instr[31]}}, instr[31:20]};
		end
	end

	always_comb begin
		case (aluOp)
			aluSub: aluResult = operandA - operandB;
			aluXor: aluResult = operandA ^ operandB;
			aluOr: aluResult = operandA | operandB;
			aluAnd: aluResult = operandA & operandB;
			default: aluResult = operandA + operandB;
		endcase
	end

	// One bit per cycle, the last bit shares its cycle with retire
	always_comb begin
		if (shiftCount == '0) begin
			nextShiftValue = shiftValue;
		end else if (aluOp == aluSll) begin
			nextShiftValue = {shiftValue[`XLEN-2:0], 1'b0};
		end else if (aluOp == aluSra) begin
			nextShiftValue = {shiftValue[`XLEN-1], shiftValue[`XLEN-1:1]};
		end else begin
			nextShiftValue = {1'b0, shiftValue[`XLEN-1:1]};
		end
	end
	assign shiftDone = shiftCount <= 5'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			shifting <= 1'b0;
		end else if (headValid && isShift && !shifting) begin
			shifting <= 1'b1;
		end else if (pop) begin
			shifting <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (headValid && isShift && !shifting) begin
			shiftValue <= operandA;
			shiftCount <= operandB[4:0];
		end else if (shifting) begin
			shiftValue <= nextShiftValue;
			shiftCount <= shiftDone ? 5'd0 : shiftCount - 5'd1;
		end
	end

	assign busy = shifting;
	assign pop = headValid && (!isShift || (shifting && shiftDone));
	assign illegal = pop && !legal;

	assign regWrite.enable = pop && legal;
	assign regWrite.index = instr[11:7];
	assign regWrite.data = isShift ? nextShiftValue : aluResult;

endmodule

`default_nettype wire

//--- fetchQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module fetchQueue import corePkg::*; (
	input wire clk,
	input wire rst,
	input wire push,
	input fetchEntry_t pushEntry,
	input wire pop,
	output logic headValid,
	output fetchEntry_t headEntry,
	output logic creditReturn,
	output logic empty
);

	localparam int PTR_WIDTH = $clog2(`QUEUE_DEPTH);

	fetchEntry_t entries [`QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] headPtr;
	logic [PTR_WIDTH-1:0] tailPtr;
	logic [`CREDIT_WIDTH-1:0] count;

	assign empty = count == '0;
	assign headValid = !empty;
	assign headEntry = entries[headPtr];

	always_ff @(posedge clk) begin
		if (push) begin
			entries[tailPtr] <= pushEntry;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			headPtr <= '0;
			tailPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (push) begin
				tailPtr <= (tailPtr == PTR_WIDTH'(`QUEUE_DEPTH - 1)) ? '0 : tailPtr + 1'b1;
			end
			if (pop) begin
				headPtr <= (headPtr == PTR_WIDTH'(`QUEUE_DEPTH - 1)) ? '0 : headPtr + 1'b1;
			end
			count <= count + `CREDIT_WIDTH'(push) - `CREDIT_WIDTH'(pop);
			// Slot freed, hand the credit back to fetch
			creditReturn <= pop;
		end
	end

	noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
		push |-> count < `CREDIT_WIDTH'(`QUEUE_DEPTH));

	noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
		pop |-> !empty);

	alignedPush: assert property (@(posedge clk) disable iff (rst)
		push |-> pushEntry.pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- instructionFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module instructionFetch import corePkg::*; (
	input wire clk,
	input wire rst,
	input wire running,
	input pcWrite_t pcWrite,
	output logic [`XLEN-1:0] instrAddress,
	output logic instrEnable,
	input wire [`XLEN-1:0] instrData,
	input wire instrBusy,
	input wire creditReturn,
	output logic push,
	output fetchEntry_t pushEntry,
	output logic [`XLEN-1:0] fetchPc
);

	logic [`XLEN-1:0] pc;
	logic [`CREDIT_WIDTH-1:0] credits;
	logic accepted;

	// Only request when the queue is known to have room
	assign instrEnable = running && (credits != '0);
	assign accepted = instrEnable && !instrBusy;
	assign instrAddress = pc;
	assign fetchPc = pc;

	assign push = accepted;
	assign pushEntry.pc = pc;
	assign pushEntry.instruction = instrData;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			credits <= `CREDIT_WIDTH'(`QUEUE_DEPTH);
		end else begin
			if (pcWrite.valid) begin
				pc <= pcWrite.value;
			end else if (accepted) begin
				pc <= pc + `XLEN'd4;
			end
			credits <= credits - `CREDIT_WIDTH'(accepted) + `CREDIT_WIDTH'(creditReturn);
		end
	end

	creditsBounded: assert property (@(posedge clk) disable iff (rst)
		credits <= `CREDIT_WIDTH'(`QUEUE_DEPTH));

	// A stalled request keeps its address until memory takes it
	addressHeldWhileBusy: assert property (@(posedge clk) disable iff (rst)
		instrEnable && instrBusy |=> instrAddress == $past(instrAddress));

endmodule

`default_nettype wire

//--- managementPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module managementPort import corePkg::*; (
	input wire clk,
	input wire rst,
	input wire run,
	input mgmtRequest_t req,
	input wire idle,
	input wire [`XLEN-1:0] pc,
	input wire [`XLEN-1:0] regReadData,
	input wire illegal,
	output logic running,
	output pcWrite_t pcWrite,
	output logic [`REG_INDEX_WIDTH-1:0] regIndex,
	output regWrite_t regWrite,
	output logic [`XLEN-1:0] readData,
	output logic error
);

	coreState_t state;
	logic [1:0] region;
	logic [`MGMT_ADDRESS_WIDTH-1:0] wordAddress;
	logic selectPc;
	logic selectClearError;
	logic selectRegister;
	logic writeAllowed;
	logic [`XLEN-1:0] dataOut;

	assign region = req.address[`MGMT_ADDRESS_WIDTH-1:`MGMT_ADDRESS_WIDTH-2];
	assign wordAddress = {req.address[`MGMT_ADDRESS_WIDTH-1:2], 2'b00};
	assign selectPc = wordAddress == `MGMT_PC_OFFSET;
	assign selectClearError = wordAddress == `MGMT_CLEAR_ERROR_OFFSET;
	// Register n at region base plus 4n
	assign selectRegister = (region == `MGMT_REGION_REGISTERS)
		&& (req.address[`MGMT_ADDRESS_WIDTH-3:7] == '0);
	assign regIndex = req.address[`REG_INDEX_WIDTH+1:2];

	assign running = state == stateRunning;
	assign writeAllowed = req.writeEnable && !running && idle;

	assign pcWrite.valid = writeAllowed && selectPc;
	assign pcWrite.value = req.writeData;
	assign regWrite.enable = writeAllowed && selectRegister;
	assign regWrite.index = regIndex;
	assign regWrite.data = req.writeData;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateHalted;
			error <= 1'b0;
		end else begin
			state <= run ? stateRunning : stateHalted;
			// Sticky until cleared
			if (illegal) begin
				error <= 1'b1;
			end else if (writeAllowed && selectClearError) begin
				error <= 1'b0;
			end
		end
	end

	always_comb begin
		if (selectPc) begin
			dataOut = pc;
		end else if (selectRegister) begin
			dataOut = regReadData;
		end else if (selectClearError) begin
			dataOut = {{(`XLEN-1){1'b0}}, error};
		end else begin
			dataOut = '1;
		end
		for (int i = 0; i < `XLEN/8; i++) begin
			readData[i*8 +: 8] = req.byteSelect[i] ? dataOut[i*8 +: 8] : 8'h00;
		end
	end

endmodule

`default_nettype wire

//--- corePkg.sv
`default_nettype none

`include "core_consts.svh"

package corePkg;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [`XLEN-1:0] instruction;
	} fetchEntry_t;

	typedef struct packed {
		logic writeEnable;
		logic [`XLEN/8-1:0] byteSelect;
		logic [`MGMT_ADDRESS_WIDTH-1:0] address;
		logic [`XLEN-1:0] writeData;
	} mgmtRequest_t;

	typedef struct packed {
		logic enable;
		logic [`REG_INDEX_WIDTH-1:0] index;
		logic [`XLEN-1:0] data;
	} regWrite_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] value;
	} pcWrite_t;

	typedef enum logic {
		stateHalted,
		stateRunning
	} coreState_t;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		opcodeOp = 7'b0110011,
		opcodeOpImm = 7'b0010011,
		opcodeLui = 7'b0110111
	} opcode_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluXor,
		aluOr,
		aluAnd,
		aluSll,
		aluSrl,
		aluSra
	} aluOp_t;

endpackage

`default_nettype wire

//--- core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Datapath
`define XLEN 32
`define REG_COUNT 32
`define REG_INDEX_WIDTH 5

// Fetch queue and credit counter, which must hold 0 to QUEUE_DEPTH
`define QUEUE_DEPTH 4
`define CREDIT_WIDTH 3

// Management address map
`define MGMT_ADDRESS_WIDTH 16
`define MGMT_REGION_SYSTEM 2'b00
`define MGMT_REGION_REGISTERS 2'b01
`define MGMT_PC_OFFSET 16'h0000
`define MGMT_CLEAR_ERROR_OFFSET 16'h0020

`endif
